// File: all.f
+incdir+include
rtl/warp_ctl_pkg.sv
rtl/elastic_buffer.sv
rtl/wctl_unit.sv
rtl/ipdom_stack.sv
rtl/barrier_table.sv
rtl/warp_state.sv
rtl/warp_ctl_top.sv
tests/tb_ref_model.sv
tests/tb_warp_ctl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the warp control testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f all.f --top-module tb_warp_ctl -o tb_warp_ctl \
    && ./obj_dir/tb_warp_ctl > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }

cat sim.log
grep -qx "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tests/tb_warp_ctl.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module tb_warp_ctl;
    import warp_ctl_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_INSTR;

    typedef struct packed {
        wctl_op_e                           op;
        logic [`NW_BITS-1:0]                wid;
        logic [`NUM_THREADS-1:0]            tmask;
        logic [`XLEN-1:0]                   pc;
        logic [`NUM_THREADS-1:0][`XLEN-1:0] rs1;
        logic [`NUM_THREADS-1:0][`XLEN-1:0] rs2;
    } instr_t;

    logic                               clk;
    logic                               reset;
    logic                               exe_valid;
    logic                               exe_ready;
    wctl_op_e                           exe_op;
    logic [`NW_BITS-1:0]                exe_wid;
    logic [`NUM_THREADS-1:0]            exe_tmask;
    logic [`XLEN-1:0]                   exe_pc;
    logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs1;
    logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs2;
    logic                               commit_valid;
    logic                               commit_ready;
    logic [`NW_BITS-1:0]                commit_wid;
    wctl_op_e                           commit_op;
    logic                               commit_dvg;
    logic [`NW_BITS-1:0]                status_wid;
    logic                               status_active;
    logic                               status_stalled;
    logic [`NUM_THREADS-1:0]            status_tmask;
    logic [`XLEN-1:0]                   status_pc;

    // accepted instructions in commit order
    instr_t sb [$];
    int     errors  = 0;
    int     commits = 0;
    int     issued  = 0;
    int     pending = 0;
    int     cycles  = 0;

    warp_ctl_top u_warp_ctl_top (
        .clk            (clk),
        .reset          (reset),
        .exe_valid      (exe_valid),
        .exe_ready      (exe_ready),
        .exe_op         (exe_op),
        .exe_wid        (exe_wid),
        .exe_tmask      (exe_tmask),
        .exe_pc         (exe_pc),
        .exe_rs1        (exe_rs1),
        .exe_rs2        (exe_rs2),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_wid     (commit_wid),
        .commit_op      (commit_op),
        .commit_dvg     (commit_dvg),
        .status_wid     (status_wid),
        .status_active  (status_active),
        .status_stalled (status_stalled),
        .status_tmask   (status_tmask),
        .status_pc      (status_pc)
    );

    tb_ref_model u_ref ();

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // holds the instruction until the DUT takes it
    task automatic issue_instr(input wctl_op_e op, input logic [`NW_BITS-1:0] wid,
                               input logic [`NUM_THREADS-1:0] tmask,
                               input logic [`NUM_THREADS-1:0] bits,
                               input logic [31:0] rs1_s, input logic [31:0] rs2_s);
        logic accepted;
        exe_valid = 1'b1;
        exe_op    = op;
        exe_wid   = wid;
        exe_tmask = tmask;
        exe_pc    = $urandom & 32'hffff_fffc;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            exe_rs1[i] = (i == 0) ? {rs1_s[31:1], bits[0]} : 32'(bits[i]);
            exe_rs2[i] = rs2_s;
        end
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = exe_ready;
            @(posedge clk);
            #1;
        end
        exe_valid = 1'b0;
        issued++;
    endtask

    task automatic issue_random();
        issue_instr(wctl_op_e'(3'($urandom % 6)), `NW_BITS'($urandom % `NUM_WARPS),
                    `NUM_THREADS'($urandom), `NUM_THREADS'($urandom),
                    $urandom % 16, $urandom % 5);
    endtask

    task automatic sweep_status();
        for (int w = 0; w < `NUM_WARPS; w++) begin
            @(posedge clk);
            #1 status_wid = `NW_BITS'(w);
            @(negedge clk);
            check_value("status_active", 32'(u_ref.active[w]), 32'(status_active));
            check_value("status_stalled", 32'(u_ref.stalled[w]), 32'(status_stalled));
            check_value("status_tmask", 32'(u_ref.tmask[w]), 32'(status_tmask));
            check_value("status_pc", u_ref.pc[w], status_pc);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic settle_and_sweep();
        while (sb.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        sweep_status();
    endtask

    // commit checks and scoreboard
    initial begin
        instr_t item;
        logic   exp_dvg;
        forever begin
            @(negedge clk);
            if (!reset) begin
                check_value("exe_ready", 32'(pending < 2), 32'(exe_ready));
                if (commit_valid && commit_ready) begin
                    if (sb.size() == 0) begin
                        errors++;
                        $display("commit at %0t with no instruction pending", $time);
                    end else begin
                        item = sb.pop_front();
                        u_ref.apply(item.op, item.wid, item.tmask, item.pc, item.rs1, item.rs2,
                                    exp_dvg);
                        check_value("commit_wid", 32'(item.wid), 32'(commit_wid));
                        check_value("commit_op", 32'(item.op), 32'(commit_op));
                        check_value("commit_dvg", 32'(exp_dvg), 32'(commit_dvg));
                        commits++;
                        pending--;
                    end
                end
                if (exe_valid && exe_ready) begin
                    item.op    = exe_op;
                    item.wid   = exe_wid;
                    item.tmask = exe_tmask;
                    item.pc    = exe_pc;
                    item.rs1   = exe_rs1;
                    item.rs2   = exe_rs2;
                    sb.push_back(item);
                    pending++;
                end
            end
        end
    end

    // consumer stalls about one cycle in four
    initial begin
        commit_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1 commit_ready = ($urandom % 4) != 0;
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", cycles);
        $display("errors: %0d, commits checked: %0d", errors, commits);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int burst;
        void'($urandom(32'hb0ae));
        reset      = 1'b1;
        exe_valid  = 1'b0;
        exe_op     = OP_TMC;
        exe_wid    = '0;
        exe_tmask  = '0;
        exe_pc     = '0;
        exe_rs1    = '0;
        exe_rs2    = '0;
        status_wid = '0;
        u_ref.reset_state();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("commit_valid", 32'd0, 32'(commit_valid));
        sweep_status();

        // spawn warps 1 to 3 at one entry point
        issue_instr(OP_WSPAWN, 2'd0, 4'hf, 4'h0, 32'd4, 32'h0000_1000);
        settle_and_sweep();
        // then path, else path, reconverge
        issue_instr(OP_SPLIT, 2'd0, 4'hf, 4'b0011, 32'd0, 32'd0);
        settle_and_sweep();
        repeat (2) begin
            issue_instr(OP_JOIN, 2'd0, 4'hf, 4'b0001, 32'd1, 32'd0);
            settle_and_sweep();
        end
        // nesting one level past the stack depth
        repeat (`IPDOM_DEPTH + 1) issue_instr(OP_SPLIT, 2'd1, 4'hf, 4'b0101, 32'd0, 32'd0);
        settle_and_sweep();
        repeat (2 * (`IPDOM_DEPTH + 1)) issue_instr(OP_JOIN, 2'd1, 4'hf, 4'b0001, 32'd1, 32'd0);
        settle_and_sweep();
        // three warps meet at barrier 2
        for (int w = 1; w < `NUM_WARPS; w++) begin
            issue_instr(OP_BAR, `NW_BITS'(w), 4'hf, 4'h0, 32'd2, 32'd3);
            settle_and_sweep();
        end

        while (issued < NUM_INSTR) begin
            burst = 1 + int'($urandom % 6);
            repeat (burst) issue_random();
            settle_and_sweep();
        end

        $display("errors: %0d, commits checked: %0d", errors, commits);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_ref_model.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module tb_ref_model;
    import warp_ctl_pkg::*;

    logic                    active  [`NUM_WARPS];
    logic                    stalled [`NUM_WARPS];
    logic [`NUM_THREADS-1:0] tmask   [`NUM_WARPS];
    logic [`XLEN-1:0]        pc      [`NUM_WARPS];

    // reconvergence stack per warp
    logic [`NUM_THREADS-1:0] stk_restore [`NUM_WARPS][`IPDOM_DEPTH];
    logic [`NUM_THREADS-1:0] stk_else    [`NUM_WARPS][`IPDOM_DEPTH];
    logic [`XLEN-1:0]        stk_pc      [`NUM_WARPS][`IPDOM_DEPTH];
    logic                    stk_taken   [`NUM_WARPS][`IPDOM_DEPTH];
    int                      sp          [`NUM_WARPS];

    int                    bar_count   [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0] bar_waiting [`NUM_BARRIERS];

    task automatic reset_state();
        for (int w = 0; w < `NUM_WARPS; w++) begin
            active[w]  = (w == 0);
            stalled[w] = 1'b0;
            tmask[w]   = (w == 0) ? {`NUM_THREADS{1'b1}} : '0;
            pc[w]      = (w == 0) ? `RESET_PC : '0;
            sp[w]      = 0;
        end
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            bar_count[b]   = 0;
            bar_waiting[b] = '0;
        end
    endtask

    // applies one committed instruction and returns the expected commit_dvg
    task automatic apply(
        input  wctl_op_e                           op,
        input  logic [`NW_BITS-1:0]                wid,
        input  logic [`NUM_THREADS-1:0]            exe_tmask,
        input  logic [`XLEN-1:0]                   exe_pc,
        input  logic [`NUM_THREADS-1:0][`XLEN-1:0] rs1,
        input  logic [`NUM_THREADS-1:0][`XLEN-1:0] rs2,
        output logic                               dvg
    );
        logic [`NUM_THREADS-1:0] taken;
        logic [`NUM_THREADS-1:0] else_mask;
        logic [`NUM_THREADS-1:0] new_mask;
        int                      top;
        int                      id;
        int                      size_m1;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            taken[i] = rs1[i][0] & exe_tmask[i];
        end
        dvg = 1'b0;
        case (op)
            OP_TMC, OP_PRED: begin
                if (op == OP_TMC) begin
                    new_mask = rs1[0][`NUM_THREADS-1:0];
                end else begin
                    new_mask = (taken != 0) ? taken : rs2[0][`NUM_THREADS-1:0];
                end
                tmask[wid]  = new_mask;
                active[wid] = (new_mask != 0);
            end
            OP_SPLIT: begin
                else_mask = ~taken & exe_tmask;
                dvg = (taken != 0) && (else_mask != 0);
                if (dvg) begin
                    // a full stack drops the entry but the mask still narrows
                    if (sp[wid] < `IPDOM_DEPTH) begin
                        stk_restore[wid][sp[wid]] = tmask[wid];
                        stk_else[wid][sp[wid]]    = else_mask;
                        stk_pc[wid][sp[wid]]      = exe_pc + 32'd4;
                        stk_taken[wid][sp[wid]]   = 1'b0;
                        sp[wid]++;
                    end
                    tmask[wid] = taken;
                end
            end
            OP_JOIN: begin
                if (rs1[0][0] && sp[wid] > 0) begin
                    top = sp[wid] - 1;
                    if (!stk_taken[wid][top]) begin
                        tmask[wid]          = stk_else[wid][top];
                        pc[wid]             = stk_pc[wid][top];
                        stk_taken[wid][top] = 1'b1;
                    end else begin
                        tmask[wid] = stk_restore[wid][top];
                        sp[wid]--;
                    end
                end
            end
            OP_BAR: begin
                id      = int'(rs1[0][`NB_BITS-1:0]);
                size_m1 = int'((rs2[0] - 32'd1) % 32'(`NUM_WARPS));
                stalled[wid] = 1'b1;
                if (bar_count[id] == size_m1) begin
                    for (int w = 0; w < `NUM_WARPS; w++) begin
                        if (bar_waiting[id][w] || w == int'(wid)) begin
                            stalled[w] = 1'b0;
                        end
                    end
                    bar_count[id]   = 0;
                    bar_waiting[id] = '0;
                end else begin
                    // arrival counter is one warp id wide
                    bar_count[id] = (bar_count[id] + 1) % `NUM_WARPS;
                    bar_waiting[id][wid] = 1'b1;
                end
            end
            OP_WSPAWN: begin
                for (int i = 0; i < `NUM_WARPS; i++) begin
                    if (rs1[0] > 32'(i) && i != int'(wid)) begin
                        active[i] = 1'b1;
                        tmask[i]  = `NUM_THREADS'(1);
                        pc[i]     = rs2[0];
                    end
                end
            end
            default: ;
        endcase
    endtask

endmodule

// File: rtl/warp_ctl_top.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module warp_ctl_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               exe_valid,
    output logic                               exe_ready,
    input  warp_ctl_pkg::wctl_op_e             exe_op,
    input  logic [`NW_BITS-1:0]                exe_wid,
    input  logic [`NUM_THREADS-1:0]            exe_tmask,
    input  logic [`XLEN-1:0]                   exe_pc,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs1,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs2,
    output logic                               commit_valid,
    input  logic                               commit_ready,
    output logic [`NW_BITS-1:0]                commit_wid,
    output warp_ctl_pkg::wctl_op_e             commit_op,
    output logic                               commit_dvg,
    input  logic [`NW_BITS-1:0]                status_wid,
    output logic                               status_active,
    output logic                               status_stalled,
    output logic [`NUM_THREADS-1:0]            status_tmask,
    output logic [`XLEN-1:0]                   status_pc
);
    import warp_ctl_pkg::*;

    // warp control event from the unit to the state
    logic                ev_valid;
    wctl_op_e            ev_op;
    logic [`NW_BITS-1:0] ev_wid;
    logic [`XLEN-1:0]    ev_pc;
    wctl_payload_u       ev_payload;

    wctl_unit u_wctl_unit (
        .clk          (clk),
        .reset        (reset),
        .exe_valid    (exe_valid),
        .exe_ready    (exe_ready),
        .exe_op       (exe_op),
        .exe_wid      (exe_wid),
        .exe_tmask    (exe_tmask),
        .exe_pc       (exe_pc),
        .exe_rs1      (exe_rs1),
        .exe_rs2      (exe_rs2),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_wid   (commit_wid),
        .commit_op    (commit_op),
        .commit_dvg   (commit_dvg),
        .ev_valid     (ev_valid),
        .ev_op        (ev_op),
        .ev_wid       (ev_wid),
        .ev_pc        (ev_pc),
        .ev_payload   (ev_payload)
    );

    warp_state u_warp_state (
        .clk            (clk),
        .reset          (reset),
        .ev_valid       (ev_valid),
        .ev_op          (ev_op),
        .ev_wid         (ev_wid),
        .ev_pc          (ev_pc),
        .ev_payload     (ev_payload),
        .status_wid     (status_wid),
        .status_active  (status_active),
        .status_stalled (status_stalled),
        .status_tmask   (status_tmask),
        .status_pc      (status_pc)
    );

endmodule

// File: rtl/warp_state.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module warp_state (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ev_valid,
    input  warp_ctl_pkg::wctl_op_e      ev_op,
    input  logic [`NW_BITS-1:0]         ev_wid,
    input  logic [`XLEN-1:0]            ev_pc,
    input  warp_ctl_pkg::wctl_payload_u ev_payload,
    input  logic [`NW_BITS-1:0]         status_wid,
    output logic                        status_active,
    output logic                        status_stalled,
    output logic [`NUM_THREADS-1:0]     status_tmask,
    output logic [`XLEN-1:0]            status_pc
);
    import warp_ctl_pkg::*;

    logic [`NUM_WARPS-1:0]   active;
    logic [`NUM_WARPS-1:0]   stalled;
    logic [`NUM_THREADS-1:0] tmask [`NUM_WARPS];
    logic [`XLEN-1:0]        pc    [`NUM_WARPS];

    logic                    stack_push;
    logic                    stack_pop;
    logic                    stack_mark;
    logic                    join_dvg;
    logic [`NUM_THREADS-1:0] top_restore_mask;
    logic [`NUM_THREADS-1:0] top_else_mask;
    logic [`XLEN-1:0]        top_else_pc;
    logic                    top_taken;
    logic                    stack_empty;
    logic                    bar_arrive;
    logic                    bar_release;
    logic [`NUM_WARPS-1:0]   release_mask;

    assign stack_push = ev_valid && (ev_op == OP_SPLIT) && ev_payload.split.dvg;
    assign join_dvg   = ev_valid && (ev_op == OP_JOIN) && ev_payload.sjoin.dvg;
    // first join takes the else path, the second one reconverges
    assign stack_mark = join_dvg && !stack_empty && !top_taken;
    assign stack_pop  = join_dvg && !stack_empty && top_taken;
    assign bar_arrive = ev_valid && (ev_op == OP_BAR);

    ipdom_stack u_ipdom (
        .clk               (clk),
        .reset             (reset),
        .push              (stack_push),
        .pop               (stack_pop),
        .mark_taken        (stack_mark),
        .wid               (ev_wid),
        .push_restore_mask (tmask[ev_wid]),
        .push_else_mask    (ev_payload.split.else_mask),
        .push_else_pc      (ev_pc + `XLEN'(ev_payload.split.else_off)),
        .top_restore_mask  (top_restore_mask),
        .top_else_mask     (top_else_mask),
        .top_else_pc       (top_else_pc),
        .top_taken         (top_taken),
        .empty             (stack_empty)
    );

    barrier_table u_barrier (
        .clk           (clk),
        .reset         (reset),
        .arrive        (bar_arrive),
        .bar_id        (ev_payload.bar.id),
        .bar_size_m1   (ev_payload.bar.size_m1),
        .wid           (ev_wid),
        .release_valid (bar_release),
        .release_mask  (release_mask)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= `NUM_WARPS'(1);
            stalled <= '0;
            for (int w = 0; w < `NUM_WARPS; w++) begin
                tmask[w] <= (w == 0) ? {`NUM_THREADS{1'b1}} : '0;
                pc[w]    <= (w == 0) ? `RESET_PC : '0;
            end
        end else begin
            if (ev_valid) begin
                case (ev_op)
                    OP_TMC, OP_PRED: begin
                        tmask[ev_wid]  <= ev_payload.tmc.tmask;
                        active[ev_wid] <= |ev_payload.tmc.tmask;
                    end
                    OP_SPLIT: begin
                        if (stack_push) begin
                            tmask[ev_wid] <= ev_payload.split.then_mask;
                        end
                    end
                    OP_JOIN: begin
                        if (stack_mark) begin
                            tmask[ev_wid] <= top_else_mask;
                            pc[ev_wid]    <= top_else_pc;
                        end else if (stack_pop) begin
                            tmask[ev_wid] <= top_restore_mask;
                        end
                    end
                    OP_BAR: stalled[ev_wid] <= 1'b1;
                    OP_WSPAWN: begin
                        for (int w = 0; w < `NUM_WARPS; w++) begin
                            if (ev_payload.wspawn.wmask[w]) begin
                                active[w] <= 1'b1;
                                tmask[w]  <= `NUM_THREADS'(1);
                                pc[w]     <= ev_payload.wspawn.pc;
                            end
                        end
                    end
                    default: ;
                endcase
            end
            // last arrival frees every waiting warp, the arriving one too
            for (int w = 0; w < `NUM_WARPS; w++) begin
                if (bar_release && release_mask[w]) begin
                    stalled[w] <= 1'b0;
                end
            end
        end
    end

    assign status_active  = active[status_wid];
    assign status_stalled = stalled[status_wid];
    assign status_tmask   = tmask[status_wid];
    assign status_pc      = pc[status_wid];

endmodule

// File: rtl/barrier_table.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module barrier_table (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  arrive,
    input  logic [`NB_BITS-1:0]   bar_id,
    input  logic [`NW_BITS-1:0]   bar_size_m1,
    input  logic [`NW_BITS-1:0]   wid,
    // release is a reserved word, hence the suffix
    output logic                  release_valid,
    output logic [`NUM_WARPS-1:0] release_mask
);
    logic [`NW_BITS-1:0]   count   [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0] waiting [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0] wid_bit;
    logic                  last_arrival;

    assign wid_bit = `NUM_WARPS'(1) << wid;

    // count before this arrival already holds size minus one
    assign last_arrival  = arrive && (count[bar_id] == bar_size_m1);
    assign release_valid = last_arrival;
    assign release_mask  = waiting[bar_id] | wid_bit;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                count[b]   <= '0;
                waiting[b] <= '0;
            end
        end else if (arrive) begin
            if (last_arrival) begin
                count[bar_id]   <= '0;
                waiting[bar_id] <= '0;
            end else begin
                count[bar_id]   <= count[bar_id] + `NW_BITS'(1);
                waiting[bar_id] <= waiting[bar_id] | wid_bit;
            end
        end
    end

endmodule

// File: rtl/ipdom_stack.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module ipdom_stack (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       mark_taken,
    input  logic [`NW_BITS-1:0]        wid,
    input  logic [`NUM_THREADS-1:0]    push_restore_mask,
    input  logic [`NUM_THREADS-1:0]    push_else_mask,
    input  logic [`XLEN-1:0]           push_else_pc,
    output logic [`NUM_THREADS-1:0]    top_restore_mask,
    output logic [`NUM_THREADS-1:0]    top_else_mask,
    output logic [`XLEN-1:0]           top_else_pc,
    output logic                       top_taken,
    output logic                       empty
);
    import warp_ctl_pkg::*;

    logic [`NUM_THREADS-1:0] restore_q [`NUM_WARPS][`IPDOM_DEPTH];
    logic [`NUM_THREADS-1:0] else_q    [`NUM_WARPS][`IPDOM_DEPTH];
    logic [`XLEN-1:0]        pc_q      [`NUM_WARPS][`IPDOM_DEPTH];
    logic                    taken_q   [`NUM_WARPS][`IPDOM_DEPTH];
    logic [SP_BITS-1:0]      sp        [`NUM_WARPS];

    logic [SP_BITS-1:0]     cur_sp;
    logic [SP_IDX_BITS-1:0] top_idx;
    logic                   full;

    assign cur_sp  = sp[wid];
    assign top_idx = SP_IDX_BITS'(cur_sp - SP_BITS'(1));
    assign full    = (cur_sp == SP_BITS'(`IPDOM_DEPTH));
    assign empty   = (cur_sp == '0);

    // top entry of the selected warp, meaningless when empty
    assign top_restore_mask = restore_q[wid][top_idx];
    assign top_else_mask    = else_q[wid][top_idx];
    assign top_else_pc      = pc_q[wid][top_idx];
    assign top_taken        = taken_q[wid][top_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                sp[w] <= '0;
            end
        end else if (push && !full) begin
            sp[wid] <= cur_sp + SP_BITS'(1);
        end else if (pop && !empty) begin
            sp[wid] <= cur_sp - SP_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            restore_q[wid][cur_sp[SP_IDX_BITS-1:0]] <= push_restore_mask;
            else_q[wid][cur_sp[SP_IDX_BITS-1:0]]    <= push_else_mask;
            pc_q[wid][cur_sp[SP_IDX_BITS-1:0]]      <= push_else_pc;
            taken_q[wid][cur_sp[SP_IDX_BITS-1:0]]   <= 1'b0;
        end
        if (mark_taken && !empty) begin
            taken_q[wid][top_idx] <= 1'b1;
        end
    end

endmodule

// File: rtl/wctl_unit.sv
`timescale 1ns/1ps
`include "warp_ctl_cfg.svh"

module wctl_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               exe_valid,
    output logic                               exe_ready,
    input  warp_ctl_pkg::wctl_op_e             exe_op,
    input  logic [`NW_BITS-1:0]                exe_wid,
    input  logic [`NUM_THREADS-1:0]            exe_tmask,
    input  logic [`XLEN-1:0]                   exe_pc,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs1,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0] exe_rs2,
    output logic                               commit_valid,
    input  logic                               commit_ready,
    output logic [`NW_BITS-1:0]                commit_wid,
    output warp_ctl_pkg::wctl_op_e             commit_op,
    output logic                               commit_dvg,
    output logic                               ev_valid,
    output warp_ctl_pkg::wctl_op_e             ev_op,
    output logic [`NW_BITS-1:0]                ev_wid,
    output logic [`XLEN-1:0]                   ev_pc,
    output warp_ctl_pkg::wctl_payload_u        ev_payload
);
    import warp_ctl_pkg::*;

    localparam int DATAW = 3 + `NW_BITS + `XLEN + WCTL_W;

    logic [`XLEN-1:0]        rs1_0;
    logic [`XLEN-1:0]        rs2_0;
    logic [`NUM_THREADS-1:0] taken;
    logic [`NUM_THREADS-1:0] else_mask;
    logic [`NUM_WARPS-1:0]   wspawn_mask;
    logic                    split_dvg;
    wctl_payload_u           payload;
    logic [DATAW-1:0]        rec_out;

    // scalar operands come from lane 0
    assign rs1_0 = exe_rs1[0];
    assign rs2_0 = exe_rs2[0];

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            taken[i] = exe_rs1[i][0] && exe_tmask[i];
        end
    end

    assign else_mask = ~taken & exe_tmask;
    assign split_dvg = (|taken) && (|else_mask);

    // warps to spawn, never the issuing one
    always_comb begin
        for (int i = 0; i < `NUM_WARPS; i++) begin
            wspawn_mask[i] = (rs1_0 > `XLEN'(i)) && (exe_wid != `NW_BITS'(i));
        end
    end

    always_comb begin
        payload = '0;
        case (exe_op)
            OP_TMC: payload.tmc.tmask = rs1_0[`NUM_THREADS-1:0];
            OP_PRED: begin
                payload.tmc.tmask = (|taken) ? taken : rs2_0[`NUM_THREADS-1:0];
            end
            OP_SPLIT: begin
                payload.split.then_mask = taken;
                payload.split.else_mask = else_mask;
                payload.split.dvg       = split_dvg;
                payload.split.else_off  = PC_OFF_W'(4);
            end
            OP_JOIN: payload.sjoin.dvg = rs1_0[0];
            OP_BAR: begin
                payload.bar.id      = rs1_0[`NB_BITS-1:0];
                payload.bar.size_m1 = `NW_BITS'(rs2_0 - `XLEN'(1));
            end
            OP_WSPAWN: begin
                payload.wspawn.wmask = wspawn_mask;
                payload.wspawn.pc    = rs2_0;
            end
            default: ;
        endcase
    end

    elastic_buffer #(
        .DATAW (DATAW)
    ) u_rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (exe_valid),
        .ready_in  (exe_ready),
        .data_in   ({exe_op, exe_wid, exe_pc, payload}),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (rec_out)
    );

    assign commit_op  = wctl_op_e'(rec_out[DATAW-1 -: 3]);
    assign commit_wid = rec_out[DATAW-4 -: `NW_BITS];
    assign ev_pc      = rec_out[WCTL_W +: `XLEN];
    assign ev_payload = rec_out[WCTL_W-1:0];
    assign commit_dvg = (commit_op == OP_SPLIT) && ev_payload.split.dvg;

    // state follows the commit handshake
    assign ev_valid = commit_valid && commit_ready;
    assign ev_op    = commit_op;
    assign ev_wid   = commit_wid;

endmodule

// File: rtl/elastic_buffer.sv
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             out_valid;
    logic             skid_valid;
    logic [DATAW-1:0] out_data;
    logic [DATAW-1:0] skid_data;
    logic             out_free;

    // output register can take a new item this cycle
    assign out_free  = ready_out || !out_valid;
    // skid entry only fills behind a full output register
    assign ready_in  = !skid_valid;
    assign valid_out = out_valid;
    assign data_out  = out_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (valid_in && ready_in) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : data_in;
        end
        if (valid_in && ready_in && !out_free) begin
            skid_data <= data_in;
        end
    end

endmodule

// File: rtl/warp_ctl_pkg.sv
`include "warp_ctl_cfg.svh"

package warp_ctl_pkg;

    typedef enum logic [2:0] {
        OP_TMC    = 3'd0,
        OP_PRED   = 3'd1,
        OP_SPLIT  = 3'd2,
        OP_JOIN   = 3'd3,
        OP_BAR    = 3'd4,
        OP_WSPAWN = 3'd5
    } wctl_op_e;

    localparam int WCTL_W      = 40;
    localparam int PC_OFF_W    = 8;
    localparam int SP_BITS     = $clog2(`IPDOM_DEPTH + 1);
    localparam int SP_IDX_BITS = $clog2(`IPDOM_DEPTH);

    // tmc and pred share this view
    typedef struct packed {
        logic [WCTL_W-`NUM_THREADS-1:0] pad;
        logic [`NUM_THREADS-1:0]        tmask;
    } tmc_view_t;

    typedef struct packed {
        logic [WCTL_W-2*`NUM_THREADS-PC_OFF_W-2:0] pad;
        logic [`NUM_THREADS-1:0]                   then_mask;
        logic [`NUM_THREADS-1:0]                   else_mask;
        logic                                      dvg;
        logic [PC_OFF_W-1:0]                       else_off;
    } split_view_t;

    typedef struct packed {
        logic [WCTL_W-2:0] pad;
        logic              dvg;
    } join_view_t;

    typedef struct packed {
        logic [WCTL_W-`NB_BITS-`NW_BITS-1:0] pad;
        logic [`NB_BITS-1:0]                 id;
        logic [`NW_BITS-1:0]                 size_m1;
    } bar_view_t;

    typedef struct packed {
        logic [WCTL_W-`NUM_WARPS-`XLEN-1:0] pad;
        logic [`NUM_WARPS-1:0]              wmask;
        logic [`XLEN-1:0]                   pc;
    } wspawn_view_t;

    // one control word, read through the view that matches the op
    typedef union packed {
        tmc_view_t    tmc;
        split_view_t  split;
        join_view_t   sjoin;
        bar_view_t    bar;
        wspawn_view_t wspawn;
    } wctl_payload_u;

endpackage

// File: include/warp_ctl_cfg.svh
`ifndef WARP_CTL_CFG_SVH
`define WARP_CTL_CFG_SVH

// lanes per warp and warps per core
`define NUM_THREADS 4
`define NUM_WARPS 4
`define NW_BITS 2

// reconvergence stack entries per warp
`define IPDOM_DEPTH 4

// barrier ids
`define NUM_BARRIERS 4
`define NB_BITS 2

// start address of warp 0
`define RESET_PC 32'h8000_0000

`define XLEN 32

`endif
